// ==== rtl/mode_ctrl_pkg.sv ====
`default_nettype none

package mode_ctrl_pkg;

    // ========================================
    // mode codes, from {mode_sw[1], mode_sw[0]}
    // ========================================
    typedef enum logic [1:0] {
        MODE_TF_UDP   = 2'b00,  // tf card to udp, not routed here
        MODE_CAM_UDP  = 2'b01,  // camera to udp, not routed here
        MODE_UDP_HDMI = 2'b10,  // udp receive to hdmi and leds
        MODE_IDLE     = 2'b11   // reserved
    } mode_e;

    // synchronized mode plus the receive gate
    typedef struct packed {
        mode_e mode;
        logic  rx_enable;
    } mode_state_t;

    // ========================================
    // reset and hold-off timing
    // ========================================
    // soft reset after master_reset, in udp_clk cycles
    localparam int SOFT_RESET_CYCLES = 255;
    localparam int SOFT_CNT_W        = 8;

    // quiet period after any change of the synchronized mode
    localparam int MODE_HOLDOFF_CYCLES = 2048;
    localparam int HOLDOFF_CNT_W       = 12;   // holds 2048 without wrapping

endpackage

`default_nettype wire

// ==== rtl/udp_rx_pkg.sv ====
`default_nettype none

package udp_rx_pkg;

    // ========================================
    // receive beats
    // ========================================
    // one byte out of the udp/ip stack
    typedef struct packed {
        logic        valid;
        logic [7:0]  data;
        logic [15:0] length;    // payload length of the whole frame
        logic [15:0] port_num;  // remote port
    } udp_rx_beat_t;

    // byte of an led frame with its position
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic [1:0] index;
    } led_beat_t;

    // byte of an hdmi frame, consumed by the video writer
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } hdmi_beat_t;

    typedef enum logic [1:0] {
        CLASS_DROP = 2'b00,
        CLASS_LED  = 2'b01,
        CLASS_HDMI = 2'b10
    } frame_class_e;

    // ========================================
    // payload limits and ports
    // ========================================
    localparam logic [15:0] LED_PAYLOAD_MAX  = 16'd3;
    localparam logic [15:0] HDMI_PAYLOAD_MIN = 16'd4;

    localparam logic [15:0] PORT_ANY         = 16'hFFFF;  // matches every remote port
    localparam logic [15:0] LED_REMOTE_PORT  = PORT_ANY;
    localparam logic [15:0] HDMI_REMOTE_PORT = PORT_ANY;

    // stalled frame is abandoned after this many idle cycles
    localparam int FRAME_IDLE_TIMEOUT = 8192;
    localparam int IDLE_CNT_W         = 13;

endpackage

`default_nettype wire

// ==== rtl/reset_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer
    import mode_ctrl_pkg::*;
(
    input  logic        udp_clk,
    input  logic        master_reset,
    input  logic [1:0]  mode_sw,
    output logic        app_reset,
    output mode_state_t mode_state
);

    mode_e                    mode_meta;     // first sync stage
    mode_e                    mode_sync;     // second sync stage, the usable mode
    logic [SOFT_CNT_W-1:0]    soft_cnt;
    logic [HOLDOFF_CNT_W-1:0] holdoff_cnt;
    logic                     mode_change;
    logic                     soft_done;
    logic                     holdoff_done;

    // ========================================
    // mode switch synchronizer
    // ========================================
    always_ff @(posedge udp_clk or posedge master_reset) begin
        if (master_reset) begin
            mode_meta <= MODE_IDLE;
            mode_sync <= MODE_IDLE;
        end else begin
            mode_meta <= mode_e'(mode_sw);
            mode_sync <= mode_meta;
        end
    end

    // mode_sync takes the new value on the next edge
    assign mode_change = (mode_meta != mode_sync);

    // ========================================
    // soft reset after master_reset
    // ========================================
    always_ff @(posedge udp_clk or posedge master_reset) begin
        if (master_reset) begin
            soft_cnt <= SOFT_CNT_W'(SOFT_RESET_CYCLES);
        end else if (!soft_done) begin
            soft_cnt <= soft_cnt - 1'b1;
        end
    end

    assign soft_done = (soft_cnt == '0);
    assign app_reset = !soft_done;  // already high while master_reset is held

    // ========================================
    // mode change hold-off
    // ========================================
    always_ff @(posedge udp_clk or posedge master_reset) begin
        if (master_reset) begin
            holdoff_cnt <= HOLDOFF_CNT_W'(MODE_HOLDOFF_CYCLES);
        end else if (mode_change) begin
            holdoff_cnt <= HOLDOFF_CNT_W'(MODE_HOLDOFF_CYCLES);  // restart on every edit
        end else if (!holdoff_done) begin
            holdoff_cnt <= holdoff_cnt - 1'b1;
        end
    end

    assign holdoff_done = (holdoff_cnt == '0);

    // receive path opens only in udp-to-hdmi mode once both counters ran out
    assign mode_state.mode      = mode_sync;
    assign mode_state.rx_enable = (mode_sync == MODE_UDP_HDMI) && soft_done && holdoff_done;

endmodule

`default_nettype wire

// ==== rtl/rx_frame_classifier.sv ====
`timescale 1ns/10ps
`default_nettype none

module rx_frame_classifier
    import mode_ctrl_pkg::*;
    import udp_rx_pkg::*;
(
    input  logic         udp_clk,
    input  logic         app_reset,
    input  mode_state_t  mode_state,
    input  udp_rx_beat_t rx_beat,
    output led_beat_t    led_beat,
    output hdmi_beat_t   hdmi_beat
);

    logic                  frame_active;
    frame_class_e          frame_class;   // class latched on the first byte
    logic [15:0]           bytes_left;
    logic [IDLE_CNT_W-1:0] idle_cnt;
    logic [1:0]            led_idx;       // index of the next byte in the frame

    logic                  led_port_ok;
    logic                  hdmi_port_ok;
    logic                  led_len_ok;
    logic                  hdmi_len_ok;
    frame_class_e          class_next;
    frame_class_e          cur_class;
    logic [1:0]            cur_index;
    logic                  frame_start;
    logic                  idle_expired;
    logic                  route_en;

    logic                  led_valid_q;
    logic                  hdmi_valid_q;
    logic [7:0]            beat_data_q;
    logic [1:0]            beat_index_q;

    // ========================================
    // classification of a new frame
    // ========================================
    assign led_port_ok  = (LED_REMOTE_PORT == PORT_ANY) ||
                          (rx_beat.port_num == LED_REMOTE_PORT);
    assign hdmi_port_ok = (HDMI_REMOTE_PORT == PORT_ANY) ||
                          (rx_beat.port_num == HDMI_REMOTE_PORT);
    assign led_len_ok   = (rx_beat.length != 16'd0) && (rx_beat.length <= LED_PAYLOAD_MAX);
    assign hdmi_len_ok  = (rx_beat.length >= HDMI_PAYLOAD_MIN);

    always_comb begin
        if (led_port_ok && led_len_ok) begin
            class_next = CLASS_LED;
        end else if (hdmi_port_ok && hdmi_len_ok) begin
            class_next = CLASS_HDMI;
        end else begin
            class_next = CLASS_DROP;
        end
    end

    assign frame_start  = rx_beat.valid && !frame_active;
    assign cur_class    = frame_active ? frame_class : class_next;
    assign cur_index    = frame_active ? led_idx : 2'd0;
    assign idle_expired = (idle_cnt == IDLE_CNT_W'(FRAME_IDLE_TIMEOUT - 1));
    assign route_en     = mode_state.rx_enable && (mode_state.mode == MODE_UDP_HDMI);

    // ========================================
    // frame tracking and idle timeout
    // ========================================
    always_ff @(posedge udp_clk or posedge app_reset) begin
        if (app_reset) begin
            frame_active <= 1'b0;
            frame_class  <= CLASS_DROP;
            bytes_left   <= 16'd0;
            idle_cnt     <= '0;
            led_idx      <= 2'd0;
        end else if (frame_start) begin
            frame_class <= class_next;
            idle_cnt    <= '0;
            led_idx     <= 2'd1;
            if (rx_beat.length <= 16'd1) begin
                frame_active <= 1'b0;   // single byte frame, done already
                bytes_left   <= 16'd0;
            end else begin
                frame_active <= 1'b1;
                bytes_left   <= rx_beat.length - 16'd1;
            end
        end else if (frame_active) begin
            if (rx_beat.valid) begin
                idle_cnt <= '0;
                led_idx  <= led_idx + 2'd1;
                if (bytes_left <= 16'd1) begin
                    frame_active <= 1'b0;  // last byte
                    bytes_left   <= 16'd0;
                end else begin
                    bytes_left <= bytes_left - 16'd1;
                end
            end else if (idle_expired) begin
                // stalled mid-payload, next valid byte opens a new frame
                frame_active <= 1'b0;
                bytes_left   <= 16'd0;
                idle_cnt     <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // ========================================
    // routed byte outputs, one cycle late
    // ========================================
    always_ff @(posedge udp_clk or posedge app_reset) begin
        if (app_reset) begin
            led_valid_q  <= 1'b0;
            hdmi_valid_q <= 1'b0;
        end else begin
            led_valid_q  <= route_en && rx_beat.valid && (cur_class == CLASS_LED);
            hdmi_valid_q <= route_en && rx_beat.valid && (cur_class == CLASS_HDMI);
        end
    end

    always_ff @(posedge udp_clk) begin
        beat_data_q  <= rx_beat.data;
        beat_index_q <= cur_index;
    end

    assign led_beat.valid  = led_valid_q;
    assign led_beat.data   = beat_data_q;
    assign led_beat.index  = beat_index_q;

    assign hdmi_beat.valid = hdmi_valid_q;
    assign hdmi_beat.data  = beat_data_q;   // shared byte register

endmodule

`default_nettype wire

// ==== rtl/led_payload_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module led_payload_decoder
    import udp_rx_pkg::*;
(
    input  logic        udp_clk,
    input  logic        app_reset,
    input  led_beat_t   led_beat,
    output logic [3:0]  led_data,
    output logic [15:0] dled
);

    // ========================================
    // led frame byte map
    // ========================================
    // byte 0 -> led_data, low nibble only
    // byte 1 -> dled high byte
    // byte 2 -> dled low byte
    // registers keep their value between frames

    always_ff @(posedge udp_clk or posedge app_reset) begin
        if (app_reset) begin
            led_data <= 4'd0;
            dled     <= 16'd0;
        end else if (led_beat.valid) begin
            case (led_beat.index)
                2'd0: begin
                    led_data <= led_beat.data[3:0];  // upper nibble ignored
                end
                2'd1: begin
                    dled[15:8] <= led_beat.data;
                end
                2'd2: begin
                    dled[7:0] <= led_beat.data;
                end
                default: begin
                    // index 3 never occurs in a 3 byte frame
                    led_data <= led_data;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/udp_mode_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module udp_mode_router
    import mode_ctrl_pkg::*;
    import udp_rx_pkg::*;
(
    input  logic         udp_clk,
    input  logic         master_reset,
    input  logic [1:0]   mode_sw,       // asynchronous board switches
    input  udp_rx_beat_t rx_beat,
    output logic [3:0]   led_data,
    output logic [15:0]  dled,
    output hdmi_beat_t   hdmi_beat,
    output logic         app_ready
);

    logic        app_reset;
    mode_state_t mode_state;
    led_beat_t   led_beat;

    // ========================================
    // reset and mode control
    // ========================================
    reset_sequencer u_reset_sequencer (
        .udp_clk      (udp_clk),
        .master_reset (master_reset),
        .mode_sw      (mode_sw),
        .app_reset    (app_reset),
        .mode_state   (mode_state)
    );

    // ========================================
    // receive path
    // ========================================
    rx_frame_classifier u_rx_frame_classifier (
        .udp_clk    (udp_clk),
        .app_reset  (app_reset),
        .mode_state (mode_state),
        .rx_beat    (rx_beat),
        .led_beat   (led_beat),
        .hdmi_beat  (hdmi_beat)     // straight out to the video writer
    );

    led_payload_decoder u_led_payload_decoder (
        .udp_clk   (udp_clk),
        .app_reset (app_reset),
        .led_beat  (led_beat),
        .led_data  (led_data),
        .dled      (dled)
    );

    assign app_ready = mode_state.rx_enable;

endmodule

`default_nettype wire

// ==== verification/udp_mode_router_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module udp_mode_router_props
    import udp_rx_pkg::*;
(
    input logic         udp_clk,
    input logic         master_reset,
    input udp_rx_beat_t rx_beat,
    input logic [3:0]   led_data,
    input logic [15:0]  dled,
    input hdmi_beat_t   hdmi_beat,
    input logic         app_ready
);

    // ========================================
    // receive gate
    // ========================================
    // gate and byte are registered on the same edge
    hdmi_after_ready: assert property (
        @(posedge udp_clk) disable iff (master_reset)
        hdmi_beat.valid |-> $past(app_ready)
    ) else $error("hdmi_beat.valid high without app_ready one cycle earlier");

    hdmi_after_input: assert property (
        @(posedge udp_clk) disable iff (master_reset)
        hdmi_beat.valid |-> $past(rx_beat.valid)
    ) else $error("hdmi_beat.valid high without an input byte one cycle earlier");

    // ========================================
    // led register timing
    // ========================================
    led_update_latency: assert property (
        @(posedge udp_clk) disable iff (master_reset)
        !$stable({led_data, dled}) |-> $past(rx_beat.valid, 2)   // byte, led_beat, regs
    ) else $error("led_data or dled changed without an input byte two cycles earlier");

endmodule

`default_nettype wire

// ==== verification/tb_udp_mode_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_udp_mode_router
    import mode_ctrl_pkg::*;
    import udp_rx_pkg::*;
();

    logic         udp_clk;
    logic         master_reset;
    logic [1:0]   mode_sw;
    udp_rx_beat_t rx_beat;
    logic [3:0]   led_data;
    logic [15:0]  dled;
    hdmi_beat_t   hdmi_beat;
    logic         app_ready;

    logic [31:0]  lfsr_state;
    logic [7:0]   exp_hdmi[$];    // hdmi bytes still to come in arrival order
    logic [3:0]   exp_led_data;
    logic [15:0]  exp_dled;

    udp_mode_router DUT (
        .udp_clk      (udp_clk),
        .master_reset (master_reset),
        .mode_sw      (mode_sw),
        .rx_beat      (rx_beat),
        .led_data     (led_data),
        .dled         (dled),
        .hdmi_beat    (hdmi_beat),
        .app_ready    (app_ready)
    );

    bind udp_mode_router udp_mode_router_props u_props (
        .udp_clk      (udp_clk),
        .master_reset (master_reset),
        .rx_beat      (rx_beat),
        .led_data     (led_data),
        .dled         (dled),
        .hdmi_beat    (hdmi_beat),
        .app_ready    (app_ready)
    );

    initial begin
        udp_clk = 1'b0;
        forever #4 udp_clk = ~udp_clk;
    end

    // ========================================
    // random source and error reporting
    // ========================================
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};  // one step per bit
        end
    endtask

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // hdmi output sampled mid-cycle where it is stable
    always @(negedge udp_clk) begin
        logic [7:0] want;
        if (hdmi_beat.valid === 1'b1) begin
            if (exp_hdmi.size() == 0) begin
                stop_run($sformatf("unexpected byte 0x%0h on hdmi_beat", hdmi_beat.data));
            end else begin
                want = exp_hdmi.pop_front();
                check_value("hdmi_beat.data", 32'(hdmi_beat.data), 32'(want));
            end
        end
    end

    // ========================================
    // stimulus and reference model
    // ========================================
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge udp_clk);
            rx_beat.valid = 1'b0;
        end
    endtask

    task automatic set_mode(input logic [1:0] m);
        @(negedge udp_clk);
        rx_beat.valid = 1'b0;
        mode_sw       = m;
    endtask

    // led frames hit the registers by byte position and longer frames go to hdmi
    task automatic model_byte(input int len, input int idx, input logic [7:0] d);
        if (len >= 1 && len <= int'(LED_PAYLOAD_MAX)) begin
            case (idx)
                0: exp_led_data = d[3:0];
                1: exp_dled[15:8] = d;
                2: exp_dled[7:0] = d;
                default: exp_led_data = exp_led_data;
            endcase
        end else if (len >= int'(HDMI_PAYLOAD_MIN)) begin
            exp_hdmi.push_back(d);
        end
    endtask

    // bytes first to last-1 of a frame of len bytes with random gaps in between
    task automatic send_bytes(input int len, input int first, input int last,
                              input logic routed, input logic [15:0] port);
        logic [31:0] r;
        for (int i = first; i < last; i++) begin
            draw_bits(8, r);
            @(negedge udp_clk);
            rx_beat.valid    = 1'b1;
            rx_beat.data     = r[7:0];
            rx_beat.length   = 16'(len);   // stack holds these for the whole frame
            rx_beat.port_num = port;
            if (routed) begin
                model_byte(len, i, r[7:0]);
            end
            draw_bits(2, r);
            if (i < last - 1) begin
                idle_cycles(int'(r[1:0]));
            end
        end
    endtask

    // led registers trail the last byte by 2 cycles and hdmi by 1
    task automatic settle_check();
        int waited;
        idle_cycles(2);
        check_value("led_data", 32'(led_data), 32'(exp_led_data));
        check_value("dled", 32'(dled), 32'(exp_dled));
        waited = 0;
        while (exp_hdmi.size() != 0) begin
            if (waited == 16) begin
                stop_run("hdmi_beat went quiet before all frame bytes came out");
            end else begin
                idle_cycles(1);
                waited++;
            end
        end
    endtask

    task automatic frame_of(input int len, input logic routed);
        logic [31:0] r;
        draw_bits(16, r);
        send_bytes(len, 0, len, routed, r[15:0]);
        settle_check();
    endtask

    task automatic random_frame(input logic routed);
        logic [31:0] r;
        draw_bits(4, r);
        frame_of(int'(r[3:0]) % 12 + 1, routed);
    endtask

    // frame cut off after sent bytes and then silent past the idle timeout
    task automatic stalled_frame(input int len, input int sent);
        send_bytes(len, 0, sent, 1'b1, PORT_ANY);
        idle_cycles(FRAME_IDLE_TIMEOUT + 16);
        settle_check();
    endtask

    task automatic wait_ready_level(input logic level, input int limit, output int cycles);
        cycles = 0;
        while (app_ready !== level) begin
            if (cycles == limit) begin
                stop_run($sformatf("app_ready did not reach %0d within %0d cycles",
                                   level, limit));
            end else begin
                idle_cycles(1);
                cycles++;
            end
        end
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        mode_e other_modes[3];
        int    waited;
        other_modes  = '{MODE_TF_UDP, MODE_CAM_UDP, MODE_IDLE};
        master_reset = 1'b1;
        mode_sw      = MODE_UDP_HDMI;
        rx_beat      = '0;
        lfsr_state   = 32'hf3b7;
        exp_led_data = 4'h0;
        exp_dled     = 16'h0000;
        repeat (3) @(posedge udp_clk);
        @(negedge udp_clk);
        master_reset = 1'b0;

        check_value("led_data", 32'(led_data), 32'h0);
        check_value("dled", 32'(dled), 32'h0);
        check_value("hdmi_beat.valid", 32'(hdmi_beat.valid), 32'h0);
        check_value("app_ready", 32'(app_ready), 32'h0);
        wait_ready_level(1'b1, 2 * MODE_HOLDOFF_CYCLES + 600, waited);

        repeat (60) random_frame(1'b1);   // lengths 1 to 12 with led and hdmi mixed

        stalled_frame(10, 4);   // hdmi frame abandoned and the next one is led
        frame_of(3, 1'b1);
        stalled_frame(3, 1);    // and the other way round
        frame_of(6, 1'b1);

        foreach (other_modes[k]) begin
            set_mode(other_modes[k]);
            wait_ready_level(1'b0, 8, waited);
            repeat (8) random_frame(1'b0);
            set_mode(MODE_UDP_HDMI);
            wait_ready_level(1'b1, 2 * MODE_HOLDOFF_CYCLES, waited);
            if (waited < MODE_HOLDOFF_CYCLES) begin
                stop_run($sformatf("app_ready rose %0d cycles after the mode change", waited));
            end
            repeat (8) random_frame(1'b1);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/mode_ctrl_pkg.sv
rtl/udp_rx_pkg.sv
rtl/reset_sequencer.sv
rtl/rx_frame_classifier.sv
rtl/led_payload_decoder.sv
rtl/udp_mode_router.sv
verification/udp_mode_router_props.sv
verification/tb_udp_mode_router.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the udp mode router testbench with verilator

cd "$(dirname "$0")" || exit 1

top=tb_udp_mode_router
build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" -Mdir "$build_dir" -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/V$top" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "TESTBENCH FAILED" "$log_file"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation finished without failures"
exit 0
